//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_top
FILELIST  = all.f

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF -- '** PASS **'

clean:
	rm -rf obj_dir

//--- all.f
+incdir+tb
logic/cpu_pkg.sv
logic/fetch.sv
logic/decoder.sv
logic/regfile.sv
logic/alu.sv
logic/hazard_unit.sv
logic/mycpu_top.sv
tb/tb_top.sv

//--- logic/alu.sv
`timescale 1ns/1ps

module alu (
    input  cpu_pkg::alu_op_t op,
    input  cpu_pkg::word_t   a,
    input  cpu_pkg::word_t   b,
    input  logic [4:0]       sa,
    output cpu_pkg::word_t   res
);

    logic lt_signed;
    logic lt_unsigned;

    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (op)
            cpu_pkg::ALU_ADD:  res = a + b;
            cpu_pkg::ALU_SUB:  res = a - b;
            cpu_pkg::ALU_AND:  res = a & b;
            cpu_pkg::ALU_OR:   res = a | b;
            cpu_pkg::ALU_XOR:  res = a ^ b;
            cpu_pkg::ALU_NOR:  res = ~(a | b);
            cpu_pkg::ALU_SLT:  res = {31'b0, lt_signed};
            cpu_pkg::ALU_SLTU: res = {31'b0, lt_unsigned};
            // shifts act on rt, which arrives on b
            cpu_pkg::ALU_SLL:  res = b << sa;
            cpu_pkg::ALU_SRL:  res = b >> sa;
            cpu_pkg::ALU_SRA:  res = $signed(b) >>> sa;
            cpu_pkg::ALU_LUI:  res = {b[15:0], 16'b0};
            default:           res = '0;
        endcase
    end

endmodule

//--- logic/cpu_pkg.sv
package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;
    typedef logic [3:0]  alu_op_t;
    typedef logic [1:0]  fwd_sel_t;

    localparam reg_idx_t REG_ZERO = 5'd0;

    // primary opcodes
    localparam opcode_t OP_SPECIAL = 6'h00;
    localparam opcode_t OP_J       = 6'h02;
    localparam opcode_t OP_BEQ     = 6'h04;
    localparam opcode_t OP_BNE     = 6'h05;
    localparam opcode_t OP_ADDIU   = 6'h09;
    localparam opcode_t OP_SLTI    = 6'h0a;
    localparam opcode_t OP_ANDI    = 6'h0c;
    localparam opcode_t OP_ORI     = 6'h0d;
    localparam opcode_t OP_XORI    = 6'h0e;
    localparam opcode_t OP_LUI     = 6'h0f;
    localparam opcode_t OP_LW      = 6'h23;
    localparam opcode_t OP_SW      = 6'h2b;

    // special function field
    localparam funct_t F_SLL  = 6'h00;
    localparam funct_t F_SRL  = 6'h02;
    localparam funct_t F_SRA  = 6'h03;
    localparam funct_t F_ADDU = 6'h21;
    localparam funct_t F_SUBU = 6'h23;
    localparam funct_t F_AND  = 6'h24;
    localparam funct_t F_OR   = 6'h25;
    localparam funct_t F_XOR  = 6'h26;
    localparam funct_t F_NOR  = 6'h27;
    localparam funct_t F_SLT  = 6'h2a;
    localparam funct_t F_SLTU = 6'h2b;

    localparam alu_op_t ALU_ADD  = 4'd0;
    localparam alu_op_t ALU_SUB  = 4'd1;
    localparam alu_op_t ALU_AND  = 4'd2;
    localparam alu_op_t ALU_OR   = 4'd3;
    localparam alu_op_t ALU_XOR  = 4'd4;
    localparam alu_op_t ALU_NOR  = 4'd5;
    localparam alu_op_t ALU_SLT  = 4'd6;
    localparam alu_op_t ALU_SLTU = 4'd7;
    localparam alu_op_t ALU_SLL  = 4'd8;
    localparam alu_op_t ALU_SRL  = 4'd9;
    localparam alu_op_t ALU_SRA  = 4'd10;
    localparam alu_op_t ALU_LUI  = 4'd11;

    localparam fwd_sel_t FWD_REG = 2'd0;
    localparam fwd_sel_t FWD_MEM = 2'd1;
    localparam fwd_sel_t FWD_WB  = 2'd2;

endpackage

//--- logic/decoder.sv
`timescale 1ns/1ps

module decoder (
    input  cpu_pkg::word_t    inst,
    input  cpu_pkg::word_t    pc,
    input  cpu_pkg::word_t    rs_val,
    input  cpu_pkg::word_t    rt_val,
    output cpu_pkg::alu_op_t  alu_op,
    output logic              use_imm,
    output cpu_pkg::word_t    imm,
    output logic              rs_ren,
    output logic              rt_ren,
    output logic              regwen,
    output cpu_pkg::reg_idx_t wreg,
    output logic              load,
    output logic              store,
    output logic              redirect,
    output cpu_pkg::word_t    target
);

    cpu_pkg::opcode_t opcode;
    cpu_pkg::funct_t  funct;
    cpu_pkg::word_t   seq_pc;
    logic             wr;
    logic             sign_ext;
    logic             is_beq;
    logic             is_bne;
    logic             is_j;

    assign opcode = inst[31:26];
    assign funct  = inst[5:0];
    assign seq_pc = pc + 32'd4;     // delay slot pc

    always_comb begin
        alu_op   = cpu_pkg::ALU_ADD;
        use_imm  = 1'b0;
        rs_ren   = 1'b0;
        rt_ren   = 1'b0;
        wr       = 1'b0;
        wreg     = inst[15:11];
        load     = 1'b0;
        store    = 1'b0;
        sign_ext = 1'b1;
        case (opcode)
            cpu_pkg::OP_SPECIAL: begin
                wr     = 1'b1;
                rs_ren = 1'b1;
                rt_ren = 1'b1;
                case (funct)
                    cpu_pkg::F_ADDU: alu_op = cpu_pkg::ALU_ADD;
                    cpu_pkg::F_SUBU: alu_op = cpu_pkg::ALU_SUB;
                    cpu_pkg::F_AND:  alu_op = cpu_pkg::ALU_AND;
                    cpu_pkg::F_OR:   alu_op = cpu_pkg::ALU_OR;
                    cpu_pkg::F_XOR:  alu_op = cpu_pkg::ALU_XOR;
                    cpu_pkg::F_NOR:  alu_op = cpu_pkg::ALU_NOR;
                    cpu_pkg::F_SLT:  alu_op = cpu_pkg::ALU_SLT;
                    cpu_pkg::F_SLTU: alu_op = cpu_pkg::ALU_SLTU;
                    cpu_pkg::F_SLL, cpu_pkg::F_SRL, cpu_pkg::F_SRA: begin
                        rs_ren = 1'b0;      // shift amount comes from sa
                        alu_op = (funct == cpu_pkg::F_SLL) ? cpu_pkg::ALU_SLL :
                                 (funct == cpu_pkg::F_SRL) ? cpu_pkg::ALU_SRL :
                                                             cpu_pkg::ALU_SRA;
                    end
                    default: begin
                        wr     = 1'b0;      // unknown function, no-op
                        rs_ren = 1'b0;
                        rt_ren = 1'b0;
                    end
                endcase
            end
            cpu_pkg::OP_ADDIU, cpu_pkg::OP_SLTI, cpu_pkg::OP_ANDI,
            cpu_pkg::OP_ORI, cpu_pkg::OP_XORI, cpu_pkg::OP_LUI: begin
                wr       = 1'b1;
                wreg     = inst[20:16];
                use_imm  = 1'b1;
                rs_ren   = opcode != cpu_pkg::OP_LUI;
                sign_ext = opcode == cpu_pkg::OP_ADDIU || opcode == cpu_pkg::OP_SLTI;
                case (opcode)
                    cpu_pkg::OP_SLTI: alu_op = cpu_pkg::ALU_SLT;
                    cpu_pkg::OP_ANDI: alu_op = cpu_pkg::ALU_AND;
                    cpu_pkg::OP_ORI:  alu_op = cpu_pkg::ALU_OR;
                    cpu_pkg::OP_XORI: alu_op = cpu_pkg::ALU_XOR;
                    cpu_pkg::OP_LUI:  alu_op = cpu_pkg::ALU_LUI;
                    default:          alu_op = cpu_pkg::ALU_ADD;
                endcase
            end
            cpu_pkg::OP_LW: begin
                wr      = 1'b1;
                wreg    = inst[20:16];
                use_imm = 1'b1;
                rs_ren  = 1'b1;
                load    = 1'b1;
            end
            cpu_pkg::OP_SW: begin
                use_imm = 1'b1;
                rs_ren  = 1'b1;
                rt_ren  = 1'b1;     // store data
                store   = 1'b1;
            end
            cpu_pkg::OP_BEQ, cpu_pkg::OP_BNE: begin
                rs_ren = 1'b1;
                rt_ren = 1'b1;
            end
            default: ;
        endcase
    end

    // writes to $0 are dropped here so they never show on debug
    assign regwen = wr && wreg != cpu_pkg::REG_ZERO;
    assign imm    = sign_ext ? {{16{inst[15]}}, inst[15:0]} : {16'b0, inst[15:0]};

    assign is_beq   = opcode == cpu_pkg::OP_BEQ;
    assign is_bne   = opcode == cpu_pkg::OP_BNE;
    assign is_j     = opcode == cpu_pkg::OP_J;
    assign redirect = is_j || (is_beq && rs_val == rt_val) || (is_bne && rs_val != rt_val);
    assign target   = is_j ? {seq_pc[31:28], inst[25:0], 2'b00}
                           : seq_pc + {{14{inst[15]}}, inst[15:0], 2'b00};

endmodule

//--- logic/fetch.sv
`timescale 1ns/1ps

module fetch #(
    parameter cpu_pkg::word_t RESET_PC = 32'hbfc0_0000
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           stall,
    input  logic           redirect,
    input  cpu_pkg::word_t target,
    output cpu_pkg::word_t pc,
    output cpu_pkg::word_t id_pc
);

    cpu_pkg::word_t pc_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q  <= RESET_PC;
            id_pc <= RESET_PC;
        end else if (!stall) begin
            pc_q  <= redirect ? target : pc_q + 32'd4;
            id_pc <= pc_q;
        end
    end

    // the sram returns data a cycle late, so while decode is frozen
    // the held instruction is fetched again to keep it on rdata
    assign pc = stall ? id_pc : pc_q;

endmodule

//--- logic/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit (
    input  cpu_pkg::reg_idx_t id_rs,
    input  cpu_pkg::reg_idx_t id_rt,
    input  logic              id_rs_ren,
    input  logic              id_rt_ren,
    input  logic              id_branch,
    input  cpu_pkg::reg_idx_t ex_rs,
    input  cpu_pkg::reg_idx_t ex_rt,
    input  logic              ex_regwen,
    input  logic              ex_load,
    input  cpu_pkg::reg_idx_t ex_wreg,
    input  logic              mem_regwen,
    input  logic              mem_load,
    input  cpu_pkg::reg_idx_t mem_wreg,
    input  logic              wb_regwen,
    input  cpu_pkg::reg_idx_t wb_wreg,
    output logic              stall,
    output cpu_pkg::fwd_sel_t id_fwd_a,
    output cpu_pkg::fwd_sel_t id_fwd_b,
    output cpu_pkg::fwd_sel_t ex_fwd_a,
    output cpu_pkg::fwd_sel_t ex_fwd_b
);

    logic rs_ex;
    logic rt_ex;
    logic rs_mem;
    logic rt_mem;

    function automatic logic hit(input cpu_pkg::reg_idx_t src, input logic wen,
                                 input cpu_pkg::reg_idx_t dst);
        return wen && src != cpu_pkg::REG_ZERO && src == dst;
    endfunction

    function automatic cpu_pkg::fwd_sel_t pick(input cpu_pkg::reg_idx_t src);
        if (hit(src, mem_regwen, mem_wreg)) begin
            return cpu_pkg::FWD_MEM;
        end else if (hit(src, wb_regwen, wb_wreg)) begin
            return cpu_pkg::FWD_WB;
        end
        return cpu_pkg::FWD_REG;
    endfunction

    assign rs_ex  = id_rs_ren && hit(id_rs, ex_regwen, ex_wreg);
    assign rt_ex  = id_rt_ren && hit(id_rt, ex_regwen, ex_wreg);
    assign rs_mem = id_rs_ren && hit(id_rs, mem_regwen && mem_load, mem_wreg);
    assign rt_mem = id_rt_ren && hit(id_rt, mem_regwen && mem_load, mem_wreg);

    // branches compare in decode, so any producer still in ex is too late
    assign stall = (id_branch && (rs_ex || rt_ex || rs_mem || rt_mem)) ||
                   (ex_load && (rs_ex || rt_ex));   // load-use

    always_comb begin
        id_fwd_a = pick(id_rs);
        id_fwd_b = pick(id_rt);
        ex_fwd_a = pick(ex_rs);
        ex_fwd_b = pick(ex_rt);
    end

endmodule

//--- logic/mycpu_top.sv
`timescale 1ns/1ps

module mycpu_top #(
    parameter cpu_pkg::word_t RESET_PC = 32'hbfc0_0000
) (
    input  logic              clk,
    input  logic              rst,

    output logic              inst_sram_en,
    output logic [3:0]        inst_sram_wen,
    output cpu_pkg::word_t    inst_sram_addr,
    output cpu_pkg::word_t    inst_sram_wdata,
    input  cpu_pkg::word_t    inst_sram_rdata,

    output logic              data_sram_en,
    output logic [3:0]        data_sram_wen,
    output cpu_pkg::word_t    data_sram_addr,
    output cpu_pkg::word_t    data_sram_wdata,
    input  cpu_pkg::word_t    data_sram_rdata,

    output cpu_pkg::word_t    debug_wb_pc,
    output logic [3:0]        debug_wb_rf_wen,
    output cpu_pkg::reg_idx_t debug_wb_rf_wnum,
    output cpu_pkg::word_t    debug_wb_rf_wdata
);

    // decode
    logic              id_valid;
    cpu_pkg::word_t    id_pc, id_inst, id_imm, id_target;
    cpu_pkg::word_t    rf_a, rf_b, id_a, id_b;
    cpu_pkg::reg_idx_t id_rs, id_rt, id_wreg;
    cpu_pkg::alu_op_t  id_alu_op;
    cpu_pkg::fwd_sel_t id_fwd_a, id_fwd_b;
    logic              id_use_imm, id_rs_ren, id_rt_ren, id_regwen;
    logic              id_load, id_store, id_redirect, id_branch, stall;
    // execute
    cpu_pkg::word_t    ex_pc, ex_a, ex_b, ex_imm, ex_a_fwd, ex_b_fwd, ex_res;
    cpu_pkg::reg_idx_t ex_rs, ex_rt, ex_wreg;
    logic [4:0]        ex_sa;
    cpu_pkg::alu_op_t  ex_alu_op;
    cpu_pkg::fwd_sel_t ex_fwd_a, ex_fwd_b;
    logic              ex_use_imm, ex_regwen, ex_load, ex_store;
    // memory
    cpu_pkg::word_t    mem_pc, mem_res, mem_wdata;
    cpu_pkg::reg_idx_t mem_wreg;
    logic              mem_regwen, mem_load, mem_store;
    // write-back
    cpu_pkg::word_t    wb_pc, wb_res, wb_wdata;
    cpu_pkg::reg_idx_t wb_wreg;
    logic              wb_regwen, wb_load;

    function automatic cpu_pkg::word_t fwd_mux(input cpu_pkg::fwd_sel_t sel,
                                               input cpu_pkg::word_t    reg_val,
                                               input cpu_pkg::word_t    mem_val,
                                               input cpu_pkg::word_t    wb_val);
        case (sel)
            cpu_pkg::FWD_MEM: return mem_val;
            cpu_pkg::FWD_WB:  return wb_val;
            default:          return reg_val;
        endcase
    endfunction

    assign inst_sram_en    = 1'b1;
    assign inst_sram_wen   = 4'b0;
    assign inst_sram_wdata = '0;

    fetch #(.RESET_PC(RESET_PC)) u_fetch (
        .clk      (clk),
        .rst      (rst),
        .stall    (stall),
        .redirect (id_redirect),
        .target   (id_target),
        .pc       (inst_sram_addr),
        .id_pc    (id_pc)
    );

    // rdata in the first cycle after reset belongs to no fetch
    always_ff @(posedge clk) begin
        id_valid <= !rst;
    end

    assign id_inst   = id_valid ? inst_sram_rdata : '0;     // bubble decodes as sll $0
    assign id_rs     = id_inst[25:21];
    assign id_rt     = id_inst[20:16];
    assign id_branch = id_inst[31:26] == cpu_pkg::OP_BEQ || id_inst[31:26] == cpu_pkg::OP_BNE;

    regfile u_regfile (
        .clk     (clk),
        .rst     (rst),
        .ra      (id_rs),
        .rb      (id_rt),
        .wen     (wb_regwen),
        .wreg    (wb_wreg),
        .wdata   (wb_wdata),
        .rdata_a (rf_a),
        .rdata_b (rf_b)
    );

    assign id_a = fwd_mux(id_fwd_a, rf_a, mem_res, wb_wdata);
    assign id_b = fwd_mux(id_fwd_b, rf_b, mem_res, wb_wdata);

    decoder u_decoder (
        .inst     (id_inst),
        .pc       (id_pc),
        .rs_val   (id_a),
        .rt_val   (id_b),
        .alu_op   (id_alu_op),
        .use_imm  (id_use_imm),
        .imm      (id_imm),
        .rs_ren   (id_rs_ren),
        .rt_ren   (id_rt_ren),
        .regwen   (id_regwen),
        .wreg     (id_wreg),
        .load     (id_load),
        .store    (id_store),
        .redirect (id_redirect),
        .target   (id_target)
    );

    hazard_unit u_hazard_unit (
        .id_rs      (id_rs),
        .id_rt      (id_rt),
        .id_rs_ren  (id_rs_ren),
        .id_rt_ren  (id_rt_ren),
        .id_branch  (id_branch),
        .ex_rs      (ex_rs),
        .ex_rt      (ex_rt),
        .ex_regwen  (ex_regwen),
        .ex_load    (ex_load),
        .ex_wreg    (ex_wreg),
        .mem_regwen (mem_regwen),
        .mem_load   (mem_load),
        .mem_wreg   (mem_wreg),
        .wb_regwen  (wb_regwen),
        .wb_wreg    (wb_wreg),
        .stall      (stall),
        .id_fwd_a   (id_fwd_a),
        .id_fwd_b   (id_fwd_b),
        .ex_fwd_a   (ex_fwd_a),
        .ex_fwd_b   (ex_fwd_b)
    );

    // ID/EX, a stall turns the slot into a bubble
    always_ff @(posedge clk) begin
        if (rst || stall) begin
            ex_regwen <= 1'b0;
            ex_load   <= 1'b0;
            ex_store  <= 1'b0;
        end else begin
            ex_regwen <= id_regwen;
            ex_load   <= id_load;
            ex_store  <= id_store;
        end
        ex_pc      <= id_pc;
        ex_a       <= id_a;
        ex_b       <= id_b;
        ex_imm     <= id_imm;
        ex_rs      <= id_rs;
        ex_rt      <= id_rt;
        ex_sa      <= id_inst[10:6];
        ex_alu_op  <= id_alu_op;
        ex_use_imm <= id_use_imm;
        ex_wreg    <= id_wreg;
    end

    assign ex_a_fwd = fwd_mux(ex_fwd_a, ex_a, mem_res, wb_wdata);
    assign ex_b_fwd = fwd_mux(ex_fwd_b, ex_b, mem_res, wb_wdata);     // also sw data

    alu u_alu (
        .op  (ex_alu_op),
        .a   (ex_a_fwd),
        .b   (ex_use_imm ? ex_imm : ex_b_fwd),
        .sa  (ex_sa),
        .res (ex_res)
    );

    // EX/MEM
    always_ff @(posedge clk) begin
        if (rst) begin
            mem_regwen <= 1'b0;
            mem_load   <= 1'b0;
            mem_store  <= 1'b0;
        end else begin
            mem_regwen <= ex_regwen;
            mem_load   <= ex_load;
            mem_store  <= ex_store;
        end
        mem_pc    <= ex_pc;
        mem_res   <= ex_res;
        mem_wdata <= ex_b_fwd;
        mem_wreg  <= ex_wreg;
    end

    assign data_sram_en    = mem_load || mem_store;
    assign data_sram_wen   = {4{mem_store}};
    assign data_sram_addr  = mem_res;       // base + offset from the alu
    assign data_sram_wdata = mem_wdata;

    // MEM/WB
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_regwen <= 1'b0;
            wb_load   <= 1'b0;
        end else begin
            wb_regwen <= mem_regwen;
            wb_load   <= mem_load;
        end
        wb_pc   <= mem_pc;
        wb_res  <= mem_res;
        wb_wreg <= mem_wreg;
    end

    assign wb_wdata = wb_load ? data_sram_rdata : wb_res;

    assign debug_wb_pc       = wb_pc;
    assign debug_wb_rf_wen   = {4{wb_regwen}};
    assign debug_wb_rf_wnum  = wb_wreg;
    assign debug_wb_rf_wdata = wb_wdata;

endmodule

//--- logic/regfile.sv
`timescale 1ns/1ps

module regfile (
    input  logic              clk,
    input  logic              rst,
    input  cpu_pkg::reg_idx_t ra,
    input  cpu_pkg::reg_idx_t rb,
    input  logic              wen,
    input  cpu_pkg::reg_idx_t wreg,
    input  cpu_pkg::word_t    wdata,
    output cpu_pkg::word_t    rdata_a,
    output cpu_pkg::word_t    rdata_b
);

    cpu_pkg::word_t regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && wreg != cpu_pkg::REG_ZERO) begin
            regs[wreg] <= wdata;
        end
    end

    assign rdata_a = (ra == cpu_pkg::REG_ZERO) ? '0 : regs[ra];
    assign rdata_b = (rb == cpu_pkg::REG_ZERO) ? '0 : regs[rb];

endmodule

//--- tb/tb_tests.svh
function automatic cpu_pkg::word_t enc_r(input cpu_pkg::funct_t funct,
                                         input cpu_pkg::reg_idx_t rs,
                                         input cpu_pkg::reg_idx_t rt,
                                         input cpu_pkg::reg_idx_t rd,
                                         input logic [4:0] sa);
    return {cpu_pkg::OP_SPECIAL, rs, rt, rd, sa, funct};
endfunction

function automatic cpu_pkg::word_t enc_i(input cpu_pkg::opcode_t op,
                                         input cpu_pkg::reg_idx_t rs,
                                         input cpu_pkg::reg_idx_t rt,
                                         input logic [15:0] imm);
    return {op, rs, rt, imm};
endfunction

function automatic cpu_pkg::word_t enc_j(input cpu_pkg::word_t target);
    return {cpu_pkg::OP_J, target[27:2]};
endfunction

function automatic cpu_pkg::word_t sext(input logic [15:0] k);
    return {{16{k[15]}}, k};
endfunction

function automatic cpu_pkg::word_t pc_of(input int idx);
    return RESET_PC + idx * 4;
endfunction

task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("** FAIL **");
    $fatal(1);
endtask

task automatic check_word(input string name, input cpu_pkg::word_t exp,
                          input cpu_pkg::word_t act);
    if (act !== exp) begin
        fail_run($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
    end
endtask

task automatic check_reg(input string name, input cpu_pkg::reg_idx_t exp,
                         input cpu_pkg::reg_idx_t act);
    if (act !== exp) begin
        fail_run($sformatf("Fail %s: expected %0d, actual %0d", name, exp, act));
    end
endtask

task automatic clear_program();
    for (int i = 0; i < IMEM_WORDS; i++) begin
        imem[i] = '0;
    end
    prog_len = 0;
    exp_pc.delete();
    exp_reg.delete();
    exp_data.delete();
endtask

task automatic emit(input cpu_pkg::word_t inst);
    imem[prog_len[5:0]] = inst;
    prog_len++;
endtask

// write expected from the instruction emitted last
task automatic expect_write(input cpu_pkg::reg_idx_t r, input cpu_pkg::word_t v);
    exp_pc.push_back(pc_of(prog_len - 1));
    exp_reg.push_back(r);
    exp_data.push_back(v);
endtask

task automatic load_word(input cpu_pkg::reg_idx_t r, input cpu_pkg::word_t v);
    emit(enc_i(cpu_pkg::OP_LUI, 5'd0, r, v[31:16]));
    expect_write(r, {v[31:16], 16'h0});
    emit(enc_i(cpu_pkg::OP_ORI, r, r, v[15:0]));
    expect_write(r, v);
endtask

task automatic reset_dut();
    @(posedge clk);
    rst <= 1'b1;
    got_pc.delete();
    got_reg.delete();
    got_data.delete();
    mem_addr.delete();
    mem_wen.delete();
    deadline = cycles + RESET_CYCLES + 40 * prog_len;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
endtask

task automatic compare_writes(input string name);
    while (got_pc.size() < exp_pc.size()) begin
        @(negedge clk);
    end
    foreach (exp_pc[i]) begin
        check_word({name, " pc"}, exp_pc[i], got_pc[i]);
        check_reg({name, " reg"}, exp_reg[i], got_reg[i]);
        check_word({name, " data"}, exp_data[i], got_data[i]);
    end
endtask

task automatic run_program(input string name);
    reset_dut();
    compare_writes(name);
endtask

task automatic reset_test();
    clear_program();
    emit(enc_i(cpu_pkg::OP_ORI, 5'd0, 5'd1, 16'h1234));
    expect_write(5'd1, 32'h0000_1234);
    reset_dut();
    @(negedge clk);
    check_word("reset fetch address", RESET_PC, inst_sram_addr);
    check_word("reset inst write enable", 32'h0, {28'h0, inst_sram_wen});
    check_word("reset inst write data", 32'h0, inst_sram_wdata);
    while (debug_wb_rf_wen === 4'b0) begin
        if (data_sram_en !== 1'b0) begin
            fail_run("data_sram_en was not low before the first write-back");
        end
        @(negedge clk);
    end
    check_word("reset write enable", 32'h0000_000f, {28'h0, debug_wb_rf_wen});
    compare_writes("reset");
endtask

task automatic alu_test();
    cpu_pkg::word_t a;
    cpu_pkg::word_t b;
    cpu_pkg::word_t r;
    logic [15:0]    k;
    logic [4:0]     sa;
    a  = $urandom();
    b  = $urandom();
    r  = $urandom();
    k  = r[15:0];
    sa = r[20:16];
    clear_program();
    load_word(5'd1, a);
    load_word(5'd2, b);
    emit(enc_r(cpu_pkg::F_ADDU, 5'd1, 5'd2, 5'd3, 5'd0));
    expect_write(5'd3, a + b);
    emit(enc_r(cpu_pkg::F_SUBU, 5'd1, 5'd2, 5'd4, 5'd0));
    expect_write(5'd4, a - b);
    emit(enc_r(cpu_pkg::F_AND, 5'd1, 5'd2, 5'd5, 5'd0));
    expect_write(5'd5, a & b);
    emit(enc_r(cpu_pkg::F_OR, 5'd1, 5'd2, 5'd6, 5'd0));
    expect_write(5'd6, a | b);
    emit(enc_r(cpu_pkg::F_XOR, 5'd1, 5'd2, 5'd7, 5'd0));
    expect_write(5'd7, a ^ b);
    emit(enc_r(cpu_pkg::F_NOR, 5'd1, 5'd2, 5'd8, 5'd0));
    expect_write(5'd8, ~(a | b));
    emit(enc_r(cpu_pkg::F_SLT, 5'd1, 5'd2, 5'd9, 5'd0));
    expect_write(5'd9, {31'b0, $signed(a) < $signed(b)});
    emit(enc_r(cpu_pkg::F_SLTU, 5'd1, 5'd2, 5'd10, 5'd0));
    expect_write(5'd10, {31'b0, a < b});
    emit(enc_r(cpu_pkg::F_SLL, 5'd0, 5'd2, 5'd11, sa));
    expect_write(5'd11, b << sa);
    emit(enc_r(cpu_pkg::F_SRL, 5'd0, 5'd2, 5'd12, sa));
    expect_write(5'd12, b >> sa);
    emit(enc_r(cpu_pkg::F_SRA, 5'd0, 5'd2, 5'd13, sa));
    expect_write(5'd13, $signed(b) >>> sa);
    emit(enc_i(cpu_pkg::OP_ADDIU, 5'd1, 5'd14, k));
    expect_write(5'd14, a + sext(k));
    emit(enc_i(cpu_pkg::OP_SLTI, 5'd1, 5'd15, k));
    expect_write(5'd15, {31'b0, $signed(a) < $signed(sext(k))});
    emit(enc_i(cpu_pkg::OP_ANDI, 5'd1, 5'd16, k));
    expect_write(5'd16, a & {16'h0, k});       // logical ops zero-extend
    emit(enc_i(cpu_pkg::OP_ORI, 5'd1, 5'd17, k));
    expect_write(5'd17, a | {16'h0, k});
    emit(enc_i(cpu_pkg::OP_XORI, 5'd1, 5'd18, k));
    expect_write(5'd18, a ^ {16'h0, k});
    emit(enc_i(cpu_pkg::OP_LUI, 5'd0, 5'd19, k));
    expect_write(5'd19, {k, 16'h0});
    run_program("alu");
endtask

task automatic forward_test();
    cpu_pkg::word_t r;
    cpu_pkg::word_t v1;
    cpu_pkg::word_t v4;
    r  = $urandom();
    v1 = {16'h0, r[15:0]};
    v4 = (v1 + v1 + v1) - (v1 + v1);
    clear_program();
    emit(enc_i(cpu_pkg::OP_ORI, 5'd0, 5'd1, r[15:0]));
    expect_write(5'd1, v1);
    emit(enc_r(cpu_pkg::F_ADDU, 5'd1, 5'd1, 5'd2, 5'd0));    // from mem
    expect_write(5'd2, v1 + v1);
    emit(enc_r(cpu_pkg::F_ADDU, 5'd2, 5'd1, 5'd3, 5'd0));    // mem and wb
    expect_write(5'd3, v1 + v1 + v1);
    emit(enc_r(cpu_pkg::F_SUBU, 5'd3, 5'd2, 5'd4, 5'd0));
    expect_write(5'd4, v4);
    emit(enc_i(cpu_pkg::OP_ORI, 5'd0, 5'd5, 16'h0100));
    expect_write(5'd5, 32'h0000_0100);
    emit(enc_i(cpu_pkg::OP_SW, 5'd5, 5'd4, 16'h0000));
    emit(enc_i(cpu_pkg::OP_LW, 5'd5, 5'd6, 16'h0000));
    expect_write(5'd6, v4);
    emit(enc_r(cpu_pkg::F_ADDU, 5'd6, 5'd6, 5'd7, 5'd0));    // load-use
    expect_write(5'd7, v4 + v4);
    emit(enc_i(cpu_pkg::OP_LW, 5'd5, 5'd8, 16'h0000));
    expect_write(5'd8, v4);
    emit(enc_i(cpu_pkg::OP_SW, 5'd5, 5'd8, 16'h0004));       // store of loaded data
    emit(enc_i(cpu_pkg::OP_LW, 5'd5, 5'd9, 16'h0004));
    expect_write(5'd9, v4);
    emit(enc_r(cpu_pkg::F_ADDU, 5'd9, 5'd7, 5'd10, 5'd0));
    expect_write(5'd10, v4 + v4 + v4);
    run_program("forwarding");
endtask

task automatic memory_test();
    cpu_pkg::word_t w1;
    cpu_pkg::word_t w2;
    cpu_pkg::word_t addrs [4];
    logic [3:0]     wens [4];
    w1 = $urandom();
    w2 = $urandom();
    addrs[0] = 32'h0000_0300 + sext(16'hfff8);
    addrs[1] = 32'h0000_0300 + sext(16'h000c);
    addrs[2] = addrs[0];
    addrs[3] = addrs[1];
    wens[0]  = 4'hf;
    wens[1]  = 4'hf;
    wens[2]  = 4'h0;
    wens[3]  = 4'h0;
    clear_program();
    emit(enc_i(cpu_pkg::OP_ORI, 5'd0, 5'd1, 16'h0300));
    expect_write(5'd1, 32'h0000_0300);
    load_word(5'd2, w1);
    load_word(5'd3, w2);
    emit(enc_i(cpu_pkg::OP_SW, 5'd1, 5'd2, 16'hfff8));
    emit(enc_i(cpu_pkg::OP_SW, 5'd1, 5'd3, 16'h000c));
    emit(enc_i(cpu_pkg::OP_LW, 5'd1, 5'd4, 16'hfff8));
    expect_write(5'd4, w1);
    emit(enc_i(cpu_pkg::OP_LW, 5'd1, 5'd5, 16'h000c));
    expect_write(5'd5, w2);
    run_program("memory");
    check_word("memory access count", 32'd4, 32'(mem_addr.size()));
    for (int i = 0; i < 4; i++) begin
        check_word("memory address", addrs[i], mem_addr[i]);
        check_word("memory write enable", {28'h0, wens[i]}, {28'h0, mem_wen[i]});
    end
endtask

task automatic branch_test(input string name, input cpu_pkg::opcode_t op,
                           input logic [15:0] a, input logic [15:0] b);
    logic taken;
    taken = (op == cpu_pkg::OP_J) || ((op == cpu_pkg::OP_BEQ) == (a == b));
    clear_program();
    emit(enc_i(cpu_pkg::OP_ORI, 5'd0, 5'd1, a));
    expect_write(5'd1, {16'h0, a});
    emit(enc_i(cpu_pkg::OP_ORI, 5'd0, 5'd2, b));
    expect_write(5'd2, {16'h0, b});
    // target is two words past the delay slot
    if (op == cpu_pkg::OP_J) begin
        emit(enc_j(pc_of(prog_len + 3)));
    end else begin
        emit(enc_i(op, 5'd1, 5'd2, 16'd2));
    end
    emit(enc_i(cpu_pkg::OP_ORI, 5'd0, 5'd3, 16'h0011));     // delay slot
    expect_write(5'd3, 32'h0000_0011);
    emit(enc_i(cpu_pkg::OP_ORI, 5'd0, 5'd4, 16'h0022));
    if (!taken) begin
        expect_write(5'd4, 32'h0000_0022);
    end
    emit(enc_i(cpu_pkg::OP_ORI, 5'd0, 5'd5, 16'h0033));
    expect_write(5'd5, 32'h0000_0033);
    run_program(name);
endtask

//--- tb/tb_top.sv
`timescale 1ns/1ps

module tb_top;

    localparam cpu_pkg::word_t RESET_PC = 32'hbfc0_0000;
    localparam int RESET_CYCLES = 8;
    localparam int IMEM_WORDS   = 64;

    logic              clk;
    logic              rst = 1'b1;
    logic              inst_sram_en;
    logic [3:0]        inst_sram_wen;
    cpu_pkg::word_t    inst_sram_addr;
    cpu_pkg::word_t    inst_sram_wdata;
    cpu_pkg::word_t    inst_sram_rdata = '0;
    logic              data_sram_en;
    logic [3:0]        data_sram_wen;
    cpu_pkg::word_t    data_sram_addr;
    cpu_pkg::word_t    data_sram_wdata;
    cpu_pkg::word_t    data_sram_rdata = '0;
    cpu_pkg::word_t    debug_wb_pc;
    logic [3:0]        debug_wb_rf_wen;
    cpu_pkg::reg_idx_t debug_wb_rf_wnum;
    cpu_pkg::word_t    debug_wb_rf_wdata;

    cpu_pkg::word_t    imem [IMEM_WORDS];
    cpu_pkg::word_t    dmem [256];
    int                prog_len = 0;
    int                cycles   = 0;
    int                deadline = RESET_CYCLES + 40 * IMEM_WORDS;

    // expected and observed write-backs, in program order
    cpu_pkg::word_t    exp_pc[$], exp_data[$], got_pc[$], got_data[$];
    cpu_pkg::reg_idx_t exp_reg[$], got_reg[$];
    cpu_pkg::word_t    mem_addr[$];
    logic [3:0]        mem_wen[$];

    mycpu_top #(.RESET_PC(RESET_PC)) mycpu_top_i (
        .clk               (clk),
        .rst               (rst),
        .inst_sram_en      (inst_sram_en),
        .inst_sram_wen     (inst_sram_wen),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_wdata   (inst_sram_wdata),
        .inst_sram_rdata   (inst_sram_rdata),
        .data_sram_en      (data_sram_en),
        .data_sram_wen     (data_sram_wen),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .data_sram_rdata   (data_sram_rdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic cpu_pkg::word_t imem_read(input cpu_pkg::word_t addr);
        cpu_pkg::word_t idx;
        idx = (addr - RESET_PC) >> 2;
        return (idx < IMEM_WORDS) ? imem[idx[5:0]] : '0;   // nop outside the program
    endfunction

    function automatic cpu_pkg::word_t merge_bytes(input cpu_pkg::word_t old,
                                                   input cpu_pkg::word_t wdata,
                                                   input logic [3:0]     wen);
        cpu_pkg::word_t w;
        w = old;
        for (int i = 0; i < 4; i++) begin
            if (wen[i]) begin
                w[8*i +: 8] = wdata[8*i +: 8];
            end
        end
        return w;
    endfunction

    always @(posedge clk) begin
        if (inst_sram_en) begin
            inst_sram_rdata <= imem_read(inst_sram_addr);
        end
    end

    always @(posedge clk) begin
        if (data_sram_en) begin
            dmem[data_sram_addr[9:2]] <= merge_bytes(dmem[data_sram_addr[9:2]],
                                                     data_sram_wdata, data_sram_wen);
            data_sram_rdata <= dmem[data_sram_addr[9:2]];
        end
    end

    // outputs are settled half a cycle after the edge
    always @(negedge clk) begin
        if (!rst && debug_wb_rf_wen != 4'b0) begin
            got_pc.push_back(debug_wb_pc);
            got_reg.push_back(debug_wb_rf_wnum);
            got_data.push_back(debug_wb_rf_wdata);
        end
        if (!rst && data_sram_en) begin
            mem_addr.push_back(data_sram_addr);
            mem_wen.push_back(data_sram_wen);
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > deadline) begin
            $display("run timed out after %0d cycles waiting for write-backs", cycles);
            $display("** FAIL **");
            $fatal(1);
        end
    end

    `include "tb_tests.svh"

    initial begin
        void'($urandom(32'h8360));
        reset_test();
        alu_test();
        forward_test();
        memory_test();
        branch_test("beq taken", cpu_pkg::OP_BEQ, 16'd5, 16'd5);
        branch_test("beq not taken", cpu_pkg::OP_BEQ, 16'd5, 16'd6);
        branch_test("bne taken", cpu_pkg::OP_BNE, 16'd3, 16'd9);
        branch_test("bne not taken", cpu_pkg::OP_BNE, 16'd7, 16'd7);
        branch_test("jump", cpu_pkg::OP_J, 16'd1, 16'd2);
        $display("** PASS **");
        $finish;
    end

endmodule
